// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module fpuClusterTb \
		-f fpuCluster.f -Mdir obj_dir -o simv
	./obj_dir/simv > sim.log; status=$$?; cat sim.log; exit $$status
	! grep -q "Result: FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/fpuPkg.sv ====
// Shared widths, opcodes, rounding modes and request/response structs of the Q16.16 FPU cluster
package fpuPkg;

    localparam int WIDTH    = 32;  // Operand and result width
    localparam int TAG_BITS = 4;   // Caller tag carried back with the result

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_DIV,      // Only multi-cycle op
        OP_MADD,
        OP_MSUB,
        OP_NMADD,
        OP_NMSUB,
        OP_SGNJ,
        OP_SGNJN,
        OP_SGNJX,
        OP_MIN,
        OP_MAX,
        OP_EQ,
        OP_LT,
        OP_LE,
        OP_CVTWS,    // Fixed to signed int
        OP_CVTWUS,   // Fixed to unsigned int
        OP_CVTSW,    // Signed int to fixed
        OP_CVTSWU    // Unsigned int to fixed
    } fpuOpE;

    // Same encoding as frm in RISC-V
    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } roundE;

    typedef struct packed {
        logic invalid;
        logic divZero;
        logic overflow;
    } fpuFlagsT;

    typedef struct packed {
        fpuOpE               op;
        roundE               frm;
        logic [TAG_BITS-1:0] tag;
        logic [WIDTH-1:0]    valA;
        logic [WIDTH-1:0]    valB;
        logic [WIDTH-1:0]    valC;
    } fpuReqT;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [WIDTH-1:0]    result;
        fpuFlagsT            flags;
    } fpuRespT;

endpackage

// ==== fpuCluster.f ====
common/fpuPkg.sv
logic/fpuDispatch.sv
fpuLane/fixDivider.sv
fpuLane/fixConvert.sv
fpuLane/fpuLane.sv
logic/fpuCollect.sv
logic/fpuCluster.sv
tb/fpuClusterTb.sv

// ==== fpuLane/fixConvert.sv ====
// Fixed/integer converter with frm rounding toward integer and saturation toward fixed point
`timescale 1ns/1ps

module fixConvert #(
    parameter int FRAC_BITS = 16
) (
    input  logic [fpuPkg::WIDTH-1:0] value,
    input  fpuPkg::fpuOpE            op,
    input  fpuPkg::roundE            frm,
    output logic [fpuPkg::WIDTH-1:0] converted,
    output logic                     invalid,
    output logic                     overflow
);
    import fpuPkg::*;

    localparam int INT_BITS = WIDTH - FRAC_BITS;
    localparam logic [WIDTH-1:0] SAT_POS = {1'b0, {(WIDTH-1){1'b1}}};
    localparam logic [WIDTH-1:0] SAT_NEG = {1'b1, {(WIDTH-1){1'b0}}};

    logic signed [WIDTH:0] intPart;   // Guard bit for the round-up carry
    logic signed [WIDTH:0] rounded;
    logic                  neg;
    logic                  half;
    logic                  rest;
    logic                  roundUp;
    logic [FRAC_BITS:0]    hiBits;    // Bits lost by the left shift plus new sign

    assign neg     = value[WIDTH-1];
    assign half    = value[FRAC_BITS-1];
    assign rest    = |value[FRAC_BITS-2:0];
    assign intPart = $signed(value) >>> FRAC_BITS;  // Floor
    assign hiBits  = value[WIDTH-1:INT_BITS-1];

    // Increment over the floored integer
    always_comb begin
        case (frm)
            RM_RTZ:  roundUp = neg && (half || rest);
            RM_RDN:  roundUp = 1'b0;
            RM_RUP:  roundUp = half || rest;
            RM_RMM:  roundUp = half && (rest || !neg);  // Ties away from zero
            default: roundUp = half && (rest || intPart[0]);  // RNE and reserved codes
        endcase
    end

    assign rounded = intPart + $signed({1'b0, roundUp});

    always_comb begin
        converted = '0;
        invalid   = 1'b0;
        overflow  = 1'b0;
        case (op)
            OP_CVTWS: begin
                if (rounded[WIDTH] != rounded[WIDTH-1]) begin
                    invalid   = 1'b1;
                    converted = rounded[WIDTH] ? SAT_NEG : SAT_POS;
                end else begin
                    converted = rounded[WIDTH-1:0];
                end
            end
            OP_CVTWUS: begin
                invalid   = rounded[WIDTH];  // Negative after rounding
                converted = rounded[WIDTH] ? '0 : rounded[WIDTH-1:0];
            end
            OP_CVTSW: begin
                if (hiBits == '0 || hiBits == '1) begin
                    converted = value << FRAC_BITS;
                end else begin
                    overflow  = 1'b1;
                    converted = neg ? SAT_NEG : SAT_POS;
                end
            end
            OP_CVTSWU: begin
                overflow  = (hiBits != '0);
                converted = (hiBits != '0) ? SAT_POS : value << FRAC_BITS;
            end
            default: converted = '0;
        endcase
    end

endmodule

// ==== fpuLane/fixDivider.sv ====
// Restoring divider for signed Q-format operands with divide-by-zero and overflow saturation
`timescale 1ns/1ps

module fixDivider #(
    parameter int FRAC_BITS = 16
) (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            go,
    input  logic signed [fpuPkg::WIDTH-1:0] dividend,
    input  logic signed [fpuPkg::WIDTH-1:0] divisor,
    output logic        [fpuPkg::WIDTH-1:0] quotient,
    output logic                            divZero,
    output logic                            overflow,
    output logic                            divDone
);
    import fpuPkg::*;

    localparam int NUM_BITS = WIDTH + FRAC_BITS;  // One quotient bit per step
    localparam int CNT_BITS = $clog2(NUM_BITS);
    localparam logic [WIDTH-1:0] SAT_POS = {1'b0, {(WIDTH-1){1'b1}}};
    localparam logic [WIDTH-1:0] SAT_NEG = {1'b1, {(WIDTH-1){1'b0}}};

    logic                running;
    logic [CNT_BITS-1:0] stepCnt;
    logic [NUM_BITS-1:0] numQ;    // Numerator shifts out as quotient shifts in
    logic [WIDTH-1:0]    remR;
    logic [WIDTH-1:0]    divMag;
    logic                negRes;
    logic                negA;
    logic                zeroDiv;
    logic [WIDTH-1:0]    magA;
    logic [WIDTH-1:0]    magB;
    logic [WIDTH:0]      trial;
    logic                trialGe;
    logic                fitsPos;
    logic                fitsNeg;

    // 0x80000000 maps to 2^31 as unsigned
    assign magA = dividend[WIDTH-1] ? -dividend : dividend;
    assign magB = divisor[WIDTH-1] ? -divisor : divisor;

    assign trial   = {remR, numQ[NUM_BITS-1]};
    assign trialGe = (trial >= {1'b0, divMag});

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
            stepCnt <= '0;
            divDone <= 1'b0;
        end else begin
            divDone <= running && (stepCnt == CNT_BITS'(NUM_BITS - 1));  // Single pulse
            if (go) begin
                running <= 1'b1;
                stepCnt <= '0;
            end else if (running) begin
                stepCnt <= stepCnt + 1'b1;
                if (stepCnt == CNT_BITS'(NUM_BITS - 1)) begin
                    running <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            numQ    <= {magA, {FRAC_BITS{1'b0}}};  // Pre-scale by FRAC_BITS
            remR    <= '0;
            divMag  <= magB;
            negRes  <= dividend[WIDTH-1] ^ divisor[WIDTH-1];
            negA    <= dividend[WIDTH-1];
            zeroDiv <= (divisor == '0);
        end else if (running) begin
            numQ <= {numQ[NUM_BITS-2:0], trialGe};
            remR <= trialGe ? WIDTH'(trial - divMag) : trial[WIDTH-1:0];
        end
    end

    // Negative side holds one more magnitude
    assign fitsPos = (numQ[NUM_BITS-1:WIDTH-1] == '0);
    assign fitsNeg = fitsPos || (numQ == (NUM_BITS'(1) << (WIDTH - 1)));

    always_comb begin
        divZero  = zeroDiv;
        overflow = 1'b0;
        if (zeroDiv) begin
            quotient = negA ? SAT_NEG : SAT_POS;  // Sign of dividend
        end else if (negRes ? !fitsNeg : !fitsPos) begin
            overflow = 1'b1;
            quotient = negRes ? SAT_NEG : SAT_POS;
        end else begin
            quotient = negRes ? WIDTH'(-numQ) : numQ[WIDTH-1:0];  // Truncates toward zero
        end
    end

endmodule

// ==== fpuLane/fpuLane.sv ====
// FPU lane decoding one request, computing single-cycle results and sequencing the divider
`timescale 1ns/1ps

module fpuLane #(
    parameter int FRAC_BITS = 16
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            start,
    input  fpuPkg::fpuReqT  laneReq,
    input  logic            ack,
    output logic            laneBusy,
    output logic            done,
    output fpuPkg::fpuRespT laneResp
);
    import fpuPkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        HOLD
    } laneStateE;

    laneStateE state;
    logic      pending;  // Single-cycle op latched and computing
    fpuReqT    curReq;

    logic signed [WIDTH-1:0]   opA;
    logic signed [WIDTH-1:0]   opB;
    logic signed [WIDTH-1:0]   opC;
    logic signed [WIDTH:0]     sumAB;
    logic signed [WIDTH:0]     difAB;
    logic signed [2*WIDTH-1:0] prodFull;
    logic signed [2*WIDTH-1:0] prodQ;
    logic signed [2*WIDTH-1:0] macRes;
    logic                      macOvf;
    logic        [WIDTH-1:0]   aluRes;
    fpuFlagsT                  aluFlags;

    logic             divGo;
    logic             divDone;
    logic             divZero;
    logic             divOvf;
    logic [WIDTH-1:0] quotient;
    logic [WIDTH-1:0] cvtRes;
    logic             cvtInvalid;
    logic             cvtOvf;

    assign opA = curReq.valA;
    assign opB = curReq.valB;
    assign opC = curReq.valC;

    // One extra bit catches signed overflow
    assign sumAB = opA + opB;
    assign difAB = opA - opB;

    assign prodFull = opA * opB;
    assign prodQ    = prodFull >>> FRAC_BITS;  // Floor toward minus infinity

    // Product or its negation, plus or minus valC
    always_comb begin
        case (curReq.op)
            OP_MADD:  macRes = prodQ + opC;
            OP_MSUB:  macRes = prodQ - opC;
            OP_NMSUB: macRes = opC - prodQ;
            OP_NMADD: macRes = -prodQ - opC;
            default:  macRes = prodQ;
        endcase
    end

    // High part must be pure sign extension
    assign macOvf = !((macRes[2*WIDTH-1:WIDTH-1] == '0) || (macRes[2*WIDTH-1:WIDTH-1] == '1));

    always_comb begin
        aluRes   = '0;
        aluFlags = '0;
        case (curReq.op)
            OP_ADD: begin
                aluRes            = sumAB[WIDTH-1:0];  // Wraps
                aluFlags.overflow = sumAB[WIDTH] ^ sumAB[WIDTH-1];
            end
            OP_SUB: begin
                aluRes            = difAB[WIDTH-1:0];
                aluFlags.overflow = difAB[WIDTH] ^ difAB[WIDTH-1];
            end
            OP_MUL, OP_MADD, OP_MSUB, OP_NMADD, OP_NMSUB: begin
                aluRes            = macRes[WIDTH-1:0];
                aluFlags.overflow = macOvf;
            end
            OP_SGNJ:  aluRes = {opB[WIDTH-1], opA[WIDTH-2:0]};
            OP_SGNJN: aluRes = {~opB[WIDTH-1], opA[WIDTH-2:0]};
            OP_SGNJX: aluRes = {opA[WIDTH-1] ^ opB[WIDTH-1], opA[WIDTH-2:0]};
            OP_MIN:   aluRes = (opA < opB) ? opA : opB;
            OP_MAX:   aluRes = (opA < opB) ? opB : opA;
            OP_EQ:    aluRes = WIDTH'(opA == opB);
            OP_LT:    aluRes = WIDTH'(opA < opB);
            OP_LE:    aluRes = WIDTH'(opA <= opB);
            OP_CVTWS, OP_CVTWUS, OP_CVTSW, OP_CVTSWU: begin
                aluRes            = cvtRes;
                aluFlags.invalid  = cvtInvalid;
                aluFlags.overflow = cvtOvf;
            end
            default:  aluFlags.invalid = 1'b1;  // Unused encodings
        endcase
    end

    fixConvert #(
        .FRAC_BITS(FRAC_BITS)
    ) uConvert (
        .value    (curReq.valA),
        .op       (curReq.op),
        .frm      (curReq.frm),
        .converted(cvtRes),
        .invalid  (cvtInvalid),
        .overflow (cvtOvf)
    );

    // Divider loads operands straight off the request bus
    assign divGo = start && (laneReq.op == OP_DIV);

    fixDivider #(
        .FRAC_BITS(FRAC_BITS)
    ) uDivider (
        .clk     (clk),
        .rstN    (rstN),
        .go      (divGo),
        .dividend(laneReq.valA),
        .divisor (laneReq.valB),
        .quotient(quotient),
        .divZero (divZero),
        .overflow(divOvf),
        .divDone (divDone)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= IDLE;
            pending <= 1'b0;
        end else begin
            pending <= start && (laneReq.op != OP_DIV);
            case (state)
                IDLE: begin
                    if (divGo) begin
                        state <= DIVIDE;
                    end else if (pending) begin
                        state <= HOLD;  // Result registered this edge
                    end
                end
                DIVIDE: begin
                    if (divDone) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            curReq <= laneReq;
        end
        if (pending) begin
            laneResp <= {curReq.tag, aluRes, aluFlags};
        end else if (state == DIVIDE && divDone) begin
            laneResp <= {curReq.tag, quotient, 1'b0, divZero, divOvf};
        end
    end

    assign laneBusy = pending || (state != IDLE);
    assign done     = (state == HOLD);

    // Dispatcher must only pick a lane that is free
    assert property (@(posedge clk) disable iff (!rstN) start |-> !laneBusy)
        else $error("fpuLane: start while busy");

endmodule

// ==== logic/fpuCluster.sv ====
// Fixed-point FPU cluster top with dispatcher, parallel lanes and response collector
`timescale 1ns/1ps

module fpuCluster #(
    parameter int NUM_LANES = 4,
    parameter int FRAC_BITS = 16
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            reqValid,
    input  fpuPkg::fpuReqT  req,
    output logic            busy,
    output logic            respValid,
    output fpuPkg::fpuRespT resp
);
    import fpuPkg::*;

    fpuReqT               laneReq;
    logic [NUM_LANES-1:0] start;
    logic [NUM_LANES-1:0] laneBusy;
    logic [NUM_LANES-1:0] laneDone;
    logic [NUM_LANES-1:0] laneAck;
    fpuRespT              laneResp [NUM_LANES];

    fpuDispatch #(
        .NUM_LANES(NUM_LANES)
    ) uDispatch (
        .clk     (clk),
        .rstN    (rstN),
        .reqValid(reqValid),
        .req     (req),
        .laneBusy(laneBusy),
        .start   (start),
        .laneReq (laneReq),
        .busy    (busy)
    );

    generate
        for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
            fpuLane #(
                .FRAC_BITS(FRAC_BITS)
            ) uLane (
                .clk     (clk),
                .rstN    (rstN),
                .start   (start[i]),
                .laneReq (laneReq),
                .ack     (laneAck[i]),
                .laneBusy(laneBusy[i]),
                .done    (laneDone[i]),
                .laneResp(laneResp[i])
            );
        end
    endgenerate

    fpuCollect #(
        .NUM_LANES(NUM_LANES)
    ) uCollect (
        .clk      (clk),
        .rstN     (rstN),
        .done     (laneDone),
        .laneResp (laneResp),
        .ack      (laneAck),
        .respValid(respValid),
        .resp     (resp)
    );

endmodule

// ==== logic/fpuCollect.sv ====
// Response collector acking the lowest finished lane and registering a one-cycle response strobe
`timescale 1ns/1ps

module fpuCollect #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [NUM_LANES-1:0] done,
    input  fpuPkg::fpuRespT      laneResp [NUM_LANES],
    output logic [NUM_LANES-1:0] ack,
    output logic                 respValid,
    output fpuPkg::fpuRespT      resp
);

    localparam int SEL_BITS = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [SEL_BITS-1:0] sel;

    // Scan down so the lowest done lane wins
    always_comb begin
        sel = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (done[i]) begin
                sel = SEL_BITS'(i);
            end
        end
    end

    // Lane releases on the edge it sees ack
    assign ack = done & (~done + 1'b1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            respValid <= 1'b0;
        end else begin
            respValid <= |done;
        end
    end

    always_ff @(posedge clk) begin
        if (|done) begin
            resp <= laneResp[sel];
        end
    end

    // At most one lane released per cycle
    assert property (@(posedge clk) disable iff (!rstN) $onehot0(ack))
        else $error("fpuCollect: ack not one-hot %b", ack);

endmodule

// ==== logic/fpuDispatch.sv ====
// Request dispatcher granting each request to the lowest idle lane and flagging a full cluster
`timescale 1ns/1ps

module fpuDispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 reqValid,
    input  fpuPkg::fpuReqT       req,
    input  logic [NUM_LANES-1:0] laneBusy,
    output logic [NUM_LANES-1:0] start,
    output fpuPkg::fpuReqT       laneReq,
    output logic                 busy
);

    logic [NUM_LANES-1:0] idle;
    logic [NUM_LANES-1:0] grant;

    assign idle  = ~laneBusy;
    assign grant = idle & (~idle + 1'b1);  // Keeps lowest idle bit only

    // Lane latches on the same edge the strobe is sampled
    assign start   = reqValid ? grant : '0;
    assign laneReq = req;                  // One bus shared by all lanes
    assign busy    = &laneBusy;            // No lane left

    // Never more than one lane started per request
    assert property (@(posedge clk) disable iff (!rstN) $onehot0(start))
        else $error("fpuDispatch: start not one-hot %b", start);

    // Caller has to hold off while the cluster reports busy
    assert property (@(posedge clk) disable iff (!rstN) reqValid |-> !busy)
        else $error("fpuDispatch: request while busy");

endmodule

// ==== tb/fpuClusterTb.sv ====
// Testbench for the Q16.16 FPU cluster, directed and random requests checked against a reference model
`timescale 1ns/1ps

module fpuClusterTb;
    import fpuPkg::*;

    localparam int NUM_LANES = 4;
    localparam int FRAC_BITS = 16;
    localparam int NUM_TAGS  = 1 << TAG_BITS;
    localparam int TIMEOUT_CYCLES = 4000;  // Tests need roughly 1500 cycles
    localparam logic [WIDTH-1:0] SAT_POS = 32'h7fff_ffff;
    localparam logic [WIDTH-1:0] SAT_NEG = 32'h8000_0000;

    logic    clk = 1'b0;
    logic    rstN;
    logic    reqValid;
    fpuReqT  req;
    logic    busy;
    logic    respValid;
    fpuRespT resp;

    logic [31:0]         lfsr = 32'h0109_918a;
    logic [TAG_BITS-1:0] nextTag = '0;
    logic [WIDTH-1:0]    expResult [NUM_TAGS];
    fpuFlagsT            expFlags [NUM_TAGS];
    logic                latCheck [NUM_TAGS];
    int                  issueCycle [NUM_TAGS];
    int                  issuedCnt [NUM_TAGS];  // Per tag, written by the issuer only
    int                  doneCnt [NUM_TAGS];    // Per tag, written by the monitor only
    int                  issuedTotal = 0;
    int                  responses = 0;
    int                  checks = 0;
    int                  errors = 0;
    int                  cycleCnt = 0;

    fpuCluster #(
        .NUM_LANES(NUM_LANES),
        .FRAC_BITS(FRAC_BITS)
    ) DUT (
        .clk      (clk),
        .rstN     (rstN),
        .reqValid (reqValid),
        .req      (req),
        .busy     (busy),
        .respValid(respValid),
        .resp     (resp)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic fitsSigned(input longint v);
        return v == longint'($signed(v[31:0]));
    endfunction

    // Reference model of one request, straight from the Q16.16 arithmetic rules
    function automatic void modelOp(input fpuReqT r, output logic [WIDTH-1:0] res,
                                    output fpuFlagsT fl);
        longint a;
        longint b;
        longint c;
        longint p;
        longint wide;
        longint flr;
        longint frac;
        longint half;
        logic   arith;
        logic   inc;
        a     = $signed(r.valA);
        b     = $signed(r.valB);
        c     = $signed(r.valC);
        p     = (a * b) >>> FRAC_BITS;  // Floor of the product
        half  = longint'(1) <<< (FRAC_BITS - 1);
        flr   = a >>> FRAC_BITS;
        frac  = a - (flr <<< FRAC_BITS);
        wide  = 0;
        arith = 1'b1;
        res   = '0;
        fl    = '0;
        case (r.op)
            OP_ADD:   wide = a + b;
            OP_SUB:   wide = a - b;
            OP_MUL:   wide = p;
            OP_MADD:  wide = p + c;
            OP_MSUB:  wide = p - c;
            OP_NMADD: wide = -p - c;
            OP_NMSUB: wide = c - p;
            default:  arith = 1'b0;
        endcase
        if (arith) begin
            res         = wide[31:0];  // Wraps
            fl.overflow = !fitsSigned(wide);
        end
        // Rounding increment on top of the floor
        case (r.frm)
            RM_RTZ:  inc = (flr < 0) && (frac != 0);
            RM_RDN:  inc = 1'b0;
            RM_RUP:  inc = (frac != 0);
            RM_RMM:  inc = (frac > half) || (frac == half && flr >= 0);
            default: inc = (frac > half) || (frac == half && flr[0]);
        endcase
        case (r.op)
            OP_DIV: begin
                if (b == 0) begin
                    fl.divZero = 1'b1;
                    res        = (a < 0) ? SAT_NEG : SAT_POS;
                end else begin
                    wide = ((a < 0 ? -a : a) <<< FRAC_BITS) / (b < 0 ? -b : b);
                    if ((a < 0) != (b < 0)) begin
                        wide = -wide;  // Truncated toward zero
                    end
                    fl.overflow = !fitsSigned(wide);
                    res = fl.overflow ? ((wide < 0) ? SAT_NEG : SAT_POS) : wide[31:0];
                end
            end
            OP_SGNJ:  res = {r.valB[31], r.valA[30:0]};
            OP_SGNJN: res = {~r.valB[31], r.valA[30:0]};
            OP_SGNJX: res = {r.valA[31] ^ r.valB[31], r.valA[30:0]};
            OP_MIN:   res = (a < b) ? r.valA : r.valB;
            OP_MAX:   res = (a > b) ? r.valA : r.valB;
            OP_EQ:    res = {31'b0, a == b};
            OP_LT:    res = {31'b0, a < b};
            OP_LE:    res = {31'b0, a <= b};
            OP_CVTWS: begin
                wide       = flr + inc;
                fl.invalid = !fitsSigned(wide);
                res        = fl.invalid ? ((wide < 0) ? SAT_NEG : SAT_POS) : wide[31:0];
            end
            OP_CVTWUS: begin
                wide       = flr + inc;
                fl.invalid = (wide < 0);  // Negative unsigned result
                res        = fl.invalid ? '0 : wide[31:0];
            end
            OP_CVTSW: begin
                wide        = a <<< FRAC_BITS;
                fl.overflow = !fitsSigned(wide);
                res         = fl.overflow ? ((a < 0) ? SAT_NEG : SAT_POS) : wide[31:0];
            end
            OP_CVTSWU: begin
                wide        = longint'(r.valA) <<< FRAC_BITS;  // Zero extended
                fl.overflow = !fitsSigned(wide);
                res         = fl.overflow ? SAT_POS : wide[31:0];
            end
            default: ;
        endcase
    endfunction

    task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic expectTrue(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("%s", what);
        end
    endtask

    // Response monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (rstN && respValid) begin
            responses++;
            expectTrue(issuedCnt[resp.tag] > doneCnt[resp.tag],
                       $sformatf("response for tag %0d which was not outstanding", resp.tag));
            if (issuedCnt[resp.tag] > doneCnt[resp.tag]) begin
                expectEq($sformatf("resp.result tag %0d", resp.tag), resp.result,
                         expResult[resp.tag]);
                expectEq($sformatf("resp.flags tag %0d", resp.tag), 32'(resp.flags),
                         32'(expFlags[resp.tag]));
                if (latCheck[resp.tag]) begin
                    expectEq($sformatf("latency tag %0d", resp.tag),
                             cycleCnt - issueCycle[resp.tag], 32'd2);
                end
                doneCnt[resp.tag]++;
            end
        end
    end

    always @(negedge clk) begin
        if (cycleCnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d responses outstanding",
                     cycleCnt, issuedTotal - responses);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Drives one request once a lane and the tag are free
    task automatic issueReq(input fpuOpE op, input roundE frm, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] c, input logic timed);
        fpuReqT           r;
        logic [WIDTH-1:0] res;
        fpuFlagsT         fl;
        while (busy || issuedCnt[nextTag] != doneCnt[nextTag]) begin
            if (busy) begin
                expectTrue(issuedTotal - responses >= NUM_LANES,
                           "busy is high while a lane should still be free");
            end
            @(posedge clk);
            #1;
        end
        r.op   = op;
        r.frm  = frm;
        r.tag  = nextTag;
        r.valA = a;
        r.valB = b;
        r.valC = c;
        modelOp(r, res, fl);
        expResult[nextTag]  = res;
        expFlags[nextTag]   = fl;
        latCheck[nextTag]   = timed && (op != OP_DIV);
        issueCycle[nextTag] = cycleCnt + 1;  // Edge that latches it
        issuedCnt[nextTag]++;
        issuedTotal++;
        req      = r;
        reqValid = 1'b1;
        @(posedge clk);
        #1;
        reqValid = 1'b0;
        nextTag  = nextTag + 1'b1;
    endtask

    task automatic waitAllDone();
        while (responses != issuedTotal) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Lone request, so no lane contention
    task automatic checkSingle(input fpuOpE op, input roundE frm, input logic [31:0] a,
                               input logic [31:0] b, input logic [31:0] c);
        issueReq(op, frm, a, b, c, 1'b1);
        waitAllDone();
    endtask

    task automatic testReset();
        expectEq("respValid", 32'(respValid), 32'd0);
        expectEq("busy", 32'(busy), 32'd0);
        repeat (8) @(posedge clk);  // Monitor flags any stray response
        #1;
    endtask

    task automatic testArith();
        fpuOpE ops [7];
        ops = '{OP_ADD, OP_SUB, OP_MUL, OP_MADD, OP_MSUB, OP_NMADD, OP_NMSUB};
        checkSingle(OP_ADD, RM_RNE, 32'h0001_8000, 32'hfffd_c000, 32'h0);
        checkSingle(OP_ADD, RM_RNE, 32'h7fff_ffff, 32'h0001_0000, 32'h0);  // Wraps
        checkSingle(OP_SUB, RM_RNE, 32'h0001_8000, 32'hfffd_c000, 32'h0);
        checkSingle(OP_SUB, RM_RNE, 32'h8000_0000, 32'h0000_0001, 32'h0);
        checkSingle(OP_MUL, RM_RNE, 32'h0001_8000, 32'hfffd_c000, 32'h0);
        checkSingle(OP_MUL, RM_RNE, 32'h0000_0001, 32'hffff_8000, 32'h0);  // Floors to -1 LSB
        checkSingle(OP_MUL, RM_RNE, 32'h0100_0000, 32'h0100_0000, 32'h0);
        for (int i = 3; i < 7; i++) begin
            checkSingle(ops[i], RM_RNE, 32'h0001_8000, 32'h0002_0000, 32'h0000_4000);
        end
        for (int i = 0; i < 12; i++) begin
            checkSingle(ops[randBits(3) % 7], RM_RNE, randBits(32), randBits(32), randBits(32));
        end
    endtask

    task automatic testDivide();
        logic [31:0] num [11];
        logic [31:0] den [11];
        num = '{32'h0007_0000, 32'hfff9_0000, 32'h0001_0000, 32'hffff_0000, 32'h0007_0000,
                32'hfff9_0000, 32'h0, 32'h4000_0000, 32'hc000_0000, 32'h8000_0000,
                32'h8000_0000};
        den = '{32'h0002_0000, 32'h0002_0000, 32'h0003_0000, 32'h0003_0000, 32'h0,
                32'h0, 32'h0, 32'h0000_0100, 32'h0000_0100, 32'h0001_0000,
                32'hffff_0000};
        for (int i = 0; i < 11; i++) begin
            checkSingle(OP_DIV, RM_RNE, num[i], den[i], 32'h0);
        end
    endtask

    task automatic testCompare();
        fpuOpE       ops [8];
        logic [31:0] lhs [5];
        logic [31:0] rhs [5];
        ops = '{OP_SGNJ, OP_SGNJN, OP_SGNJX, OP_MIN, OP_MAX, OP_EQ, OP_LT, OP_LE};
        lhs = '{32'hffff_0000, 32'h0000_8000, 32'h0001_8000, 32'h8000_0000, 32'hfffd_c000};
        rhs = '{32'h0000_8000, 32'hffff_0000, 32'h0001_8000, 32'h7fff_ffff, 32'hffff_0000};
        for (int k = 0; k < 8; k++) begin
            for (int i = 0; i < 5; i++) begin
                checkSingle(ops[k], RM_RNE, lhs[i], rhs[i], 32'h0);
            end
        end
    endtask

    task automatic testConvert();
        logic [31:0] fix [10];
        logic [31:0] ints [8];
        // Halves, quarters, and both Q extremes
        fix  = '{32'h0002_8000, 32'h0003_8000, 32'hfffd_8000, 32'hfffc_8000, 32'h0001_4000,
                 32'hfffe_4000, 32'hffff_c000, 32'h7fff_ffff, 32'h8000_0000, 32'h0};
        ints = '{32'd5, 32'hffff_fffb, 32'h0000_7fff, 32'hffff_8000, 32'h0000_8000,
                 32'hffff_7fff, 32'h7fff_ffff, 32'hffff_ffff};
        for (int m = 0; m < 5; m++) begin
            for (int i = 0; i < 10; i++) begin
                checkSingle(OP_CVTWS, roundE'(m), fix[i], 32'h0, 32'h0);
                checkSingle(OP_CVTWUS, roundE'(m), fix[i], 32'h0, 32'h0);
            end
        end
        for (int i = 0; i < 8; i++) begin
            checkSingle(OP_CVTSW, RM_RNE, ints[i], 32'h0, 32'h0);
            checkSingle(OP_CVTSWU, RM_RNE, ints[i], 32'h0, 32'h0);
        end
    endtask

    task automatic testParallel();
        fpuOpE op;
        for (int i = 0; i < NUM_LANES; i++) begin
            issueReq(OP_DIV, RM_RNE, randBits(32), randBits(20), 32'h0, 1'b0);
        end
        expectTrue(busy, "busy stayed low with four divides outstanding");
        for (int i = 0; i < 44; i++) begin
            op = (randBits(2) == 0) ? OP_DIV : fpuOpE'(randBits(5) % 20);
            issueReq(op, roundE'(randBits(3) % 5), randBits(32), randBits(32), randBits(32),
                     1'b0);
        end
        waitAllDone();
    endtask

    initial begin
        rstN     = 1'b0;
        reqValid = 1'b0;
        req      = '0;
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        testReset();
        testArith();
        testDivide();
        testCompare();
        testConvert();
        testParallel();
        repeat (4) @(posedge clk);
        expectTrue(responses == issuedTotal, "not every issued tag came back");
        $display("checks %0d, errors %0d, responses %0d of %0d issued",
                 checks, errors, responses, issuedTotal);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
